/* bench/tb_vga_checks.svh */
`ifndef TB_VGA_CHECKS_SVH
`define TB_VGA_CHECKS_SVH

task automatic stop_with_failure(input string what);
	$display("%s", what);
	$display("TEST FAILED");
	$fatal(1, "run stopped at first error");
endtask

task automatic compare_rgb(input string name, input rgb_t expected, input rgb_t actual);
	if (actual !== expected)
		stop_with_failure($sformatf("mismatch %s: expected %h, actual %h at column %0d row %0d",
			name, expected, actual, pin_column(), pin_row()));
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected)
		stop_with_failure($sformatf("mismatch %s: expected %h, actual %h at column %0d row %0d",
			name, expected, actual, pin_column(), pin_row()));
endtask

task automatic compare_pos(input string name, input pos_t expected, input pos_t actual);
	if (actual !== expected)
		stop_with_failure($sformatf("mismatch %s: expected %h, actual %h at column %0d row %0d",
			name, expected, actual, pin_column(), pin_row()));
endtask

task automatic compare_count(input string name, input int expected, input int actual);
	if (actual != expected)
		stop_with_failure($sformatf("mismatch %s: expected %h, actual %h",
			name, expected, actual));
endtask

function automatic rgb_t pixel_reference(pos_t x, pos_t y, colour_t k);
	rgb_t c;
	pos_t sum;
	sum = x + y;
	c.red = x[7:0] ^ k;
	c.green = y[7:0];
	c.blue = sum[7:0];
	return c;
endfunction

function automatic rgb_t expected_colour(pattern_mode_t mode, int col, int row);
	rgb_t c;
	c = '0;
	if (col < H_ACTIVE && row < V_ACTIVE) begin
		case (mode)
			PAT_BARS: begin
				case (col / (H_ACTIVE / 8))
					0: c = 24'hff_ffff; // White
					1: c = 24'hff_ff00;
					2: c = 24'h00_ffff;
					3: c = 24'h00_ff00;
					4: c = 24'hff_00ff;
					5: c = 24'hff_0000;
					6: c = 24'h00_00ff;
					default: c = '0;
				endcase
			end
			PAT_CHECKER: c = (col[5] != row[5]) ? 24'hff_ffff : '0;
			PAT_RAMP: begin
				c.red = col[7:0];
				c.green = row[7:0];
				c.blue = '0;
			end
			default: c = pixel_reference(pos_t'(col), pos_t'(row), key);
		endcase
	end
	return c;
endfunction

task automatic check_pixel(input pattern_mode_t mode);
	int col;
	int row;
	int beam_col;
	int beam_row;
	logic beam_active;
	col = pin_column();
	row = pin_row();
	beam_col = (pin_index() + 2) % H_TOTAL; // Beam runs two pixels ahead of the pins
	beam_row = ((pin_index() + 2) / H_TOTAL) % V_TOTAL;
	beam_active = beam_col < H_ACTIVE && beam_row < V_ACTIVE;
	compare_bit("blank_n", col < H_ACTIVE && row < V_ACTIVE, blank_n);
	compare_bit("hsync_n", !(col >= HS_START && col < HS_END), hsync_n);
	compare_bit("vsync_n", !(row >= VS_START && row < VS_END), vsync_n);
	compare_rgb("colour", expected_colour(mode, col, row), {red, green, blue});
	compare_pos("next_x", beam_active ? pos_t'(beam_col) : pos_t'(0), next_x);
	compare_pos("next_y", beam_active ? pos_t'(beam_row) : pos_t'(0), next_y);
endtask

task automatic check_idle();
	compare_bit("hsync_n", 1'b1, hsync_n);
	compare_bit("vsync_n", 1'b1, vsync_n);
	compare_bit("blank_n", 1'b0, blank_n);
	compare_rgb("colour", '0, {red, green, blue});
endtask

task automatic cycles_until(input pin_sel_t sel, input logic level, output int n);
	n = 0;
	do begin
		@(negedge clk_in);
		n++;
		if (n > FRAME_CYCLES)
			stop_with_failure("a sync or blank pin never reached the awaited level");
	end while (pin_level(sel) !== level);
endtask

task automatic wait_frame_start();
	int n;
	n = 0;
	do begin
		@(negedge clk_in);
		n++;
		if (n > FRAME_CYCLES)
			stop_with_failure("no frame start reached the pins within one frame");
	end while (pin_index() % FRAME_CYCLES != 0);
endtask

// Starts on the negedge of the span's first pixel
task automatic check_span(input pattern_mode_t mode, input int pixels, input int switch_row,
	input pattern_mode_t next_mode);
	for (int p = 0; p < pixels; p++) begin
		if (p != 0)
			@(negedge clk_in);
		check_pixel(mode);
		if (pin_column() == 0 && pin_row() == switch_row) begin
			@(posedge clk_in);
			pattern_mode <= next_mode;
		end
	end
endtask

task automatic reset_sequence();
	for (int i = 0; i < 16; i++) begin
		@(posedge clk_in);
		if (i == 15)
			reset <= 1'b0;
		@(negedge clk_in);
		check_idle();
	end
	@(negedge clk_in); // Pipeline still filling
	check_idle();
	@(negedge clk_in);
	check_pixel(PAT_EXTERNAL); // Column 0 of row 0
endtask

task automatic horizontal_timing();
	int n;
	int low;
	int high;
	cycles_until(PIN_BLANK, 1'b0, high);
	compare_count("blank_n high cycles", H_ACTIVE, high);
	cycles_until(PIN_HSYNC, 1'b0, n);
	compare_count("blank_n rise to hsync_n fall", HS_START, high + n);
	for (int i = 0; i < 2; i++) begin
		cycles_until(PIN_HSYNC, 1'b1, low);
		cycles_until(PIN_HSYNC, 1'b0, high);
		compare_count("hsync_n low cycles", H_PULSE, low);
		compare_count("hsync_n period", H_TOTAL, low + high);
	end
endtask

task automatic vertical_timing();
	int n;
	int low;
	int total;
	int lines;
	int active_lines;
	int run;
	logic prev_v;
	logic prev_h;
	logic done;
	cycles_until(PIN_VSYNC, 1'b0, n);
	low = 1;
	total = 0;
	lines = 0;
	active_lines = 0;
	run = 0;
	prev_v = 1'b0;
	prev_h = hsync_n;
	done = 1'b0;
	// One full frame, vsync fall to vsync fall
	while (!done) begin
		@(negedge clk_in);
		total++;
		if (prev_v && !vsync_n) begin
			done = 1'b1;
		end else begin
			if (!vsync_n)
				low++;
			if (prev_h && !hsync_n)
				lines++;
			if (blank_n) begin
				run++;
			end else if (run != 0) begin
				compare_count("blank_n high cycles in a line", H_ACTIVE, run);
				active_lines++;
				run = 0;
			end
		end
		prev_v = vsync_n;
		prev_h = hsync_n;
	end
	compare_count("vsync_n low cycles", V_PULSE * H_TOTAL, low);
	compare_count("frame cycles", FRAME_CYCLES, total);
	compare_count("lines per frame", V_TOTAL, lines);
	compare_count("active lines", V_ACTIVE, active_lines);
endtask

task automatic external_frame();
	wait_frame_start();
	check_span(PAT_EXTERNAL, FRAME_CYCLES, SWITCH_BLANK_ROW, PAT_BARS);
endtask

task automatic pattern_frames();
	wait_frame_start();
	check_span(PAT_BARS, FRAME_CYCLES, SWITCH_BLANK_ROW, PAT_CHECKER);
	wait_frame_start();
	check_span(PAT_CHECKER, FRAME_CYCLES, SWITCH_BLANK_ROW, PAT_RAMP);
endtask

// Ramp frame switched halfway, new mode only from the next frame
task automatic mode_switch();
	wait_frame_start();
	check_span(PAT_RAMP, FRAME_CYCLES, SWITCH_MID_ROW, PAT_EXTERNAL);
	wait_frame_start();
	check_span(PAT_EXTERNAL, 2 * H_TOTAL, -1, PAT_EXTERNAL);
endtask

`endif

/* bench/tb_vga_top.sv */
`timescale 1ns/1ps

module tb_vga_top;
	import vga_pkg::*;

	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_PULSE = 96;
	localparam int H_BACK = 48;
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_PULSE = 2;
	localparam int V_BACK = 33;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END = HS_START + H_PULSE;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END = VS_START + V_PULSE;
	localparam int SWITCH_BLANK_ROW = 500; // Inside vertical blanking
	localparam int SWITCH_MID_ROW = V_ACTIVE / 2;
	localparam int CLK_PERIOD = 10;
	localparam int TEST_FRAMES = 6;
	localparam int WATCHDOG_NS = TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD * 3 / 2;

	typedef enum {PIN_HSYNC, PIN_VSYNC, PIN_BLANK} pin_sel_t;

	logic clk_in = 1'b0;
	logic reset;
	pattern_mode_t pattern_mode;
	rgb_t pixel_color;
	pos_t next_x;
	pos_t next_y;
	logic hsync_n;
	logic vsync_n;
	logic blank_n;
	colour_t red;
	colour_t green;
	colour_t blue;
	int seed;
	colour_t key; // XOR key for the external red channel
	int edges = 0; // Rising edges since reset was released

	// Pixel at the pins, two edges behind the beam
	function automatic int pin_index();
		return edges - 2;
	endfunction

	function automatic int pin_column();
		return pin_index() % H_TOTAL;
	endfunction

	function automatic int pin_row();
		return (pin_index() / H_TOTAL) % V_TOTAL;
	endfunction

	function automatic logic pin_level(pin_sel_t sel);
		case (sel)
			PIN_HSYNC: return hsync_n;
			PIN_VSYNC: return vsync_n;
			default: return blank_n;
		endcase
	endfunction

	`include "tb_vga_checks.svh"

	always #(CLK_PERIOD / 2) clk_in = ~clk_in;

	// External source answers in the same cycle
	assign pixel_color = pixel_reference(next_x, next_y, key);

	always @(posedge clk_in) begin
		if (reset)
			edges <= 0;
		else
			edges <= edges + 1;
	end

	vga_top u_dut (
		.clk_in(clk_in),
		.reset(reset),
		.pattern_mode(pattern_mode),
		.pixel_color(pixel_color),
		.next_x(next_x),
		.next_y(next_y),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure($sformatf("timeout: tests still running after %0d ns", WATCHDOG_NS));
	end

	initial begin
		seed = 32'hcbf4_c440;
		key = colour_t'($random(seed));
		reset = 1'b1;
		pattern_mode = PAT_EXTERNAL;

		reset_sequence();
		horizontal_timing();
		vertical_timing();
		external_frame();
		pattern_frames();
		mode_switch();

		$display("TEST OK");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the vga_video testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_vga_top \
	-Mdir "$BUILD_DIR" -f vga_video.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_vga_top" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation passed"
exit 0

/* src/vga_dac_output.sv */
`timescale 1ns/1ps

module vga_dac_output (
	input logic clk_in,
	input logic reset,
	input vga_pkg::beam_t beam_d,
	input vga_pkg::rgb_t colour,
	output logic hsync_n,
	output logic vsync_n,
	output logic blank_n,
	output vga_pkg::colour_t red,
	output vga_pkg::colour_t green,
	output vga_pkg::colour_t blue
);
	import vga_pkg::*;

	rgb_t shown; // Colour after blanking

	// DAC must see black outside active video
	assign shown = beam_d.active ? colour : '0;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			hsync_n <= beam_d.hsync_n;
			vsync_n <= beam_d.vsync_n;
			blank_n <= beam_d.active;
			red <= shown.red;
			green <= shown.green;
			blue <= shown.blue;
		end
	end

	// Pins stay black whenever the DAC is blanked
	assert property (@(posedge clk_in) disable iff (reset)
		!blank_n |-> (red == '0 && green == '0 && blue == '0))
		else $error("vga_dac_output: colour present while blanked");

endmodule

/* src/vga_pixel_source.sv */
`timescale 1ns/1ps

module vga_pixel_source #(
	parameter int H_ACTIVE = 640
) (
	input logic clk_in,
	input logic reset,
	input vga_pkg::beam_t beam,
	input vga_pkg::pattern_mode_t pattern_mode,
	input vga_pkg::rgb_t pixel_color,
	output vga_pkg::pos_t next_x,
	output vga_pkg::pos_t next_y,
	output vga_pkg::rgb_t colour,
	output vga_pkg::beam_t beam_d
);
	import vga_pkg::*;

	localparam int BAR_W = H_ACTIVE / 8; // Eight bars across the line

	pattern_mode_t mode_q;
	pattern_mode_t mode; // Mode in force for this pixel
	logic [2:0] bar;
	logic check;
	rgb_t pattern_rgb;

	// Coordinates for the external source, zero in blanking
	assign next_x = beam.active ? beam.x : '0;
	assign next_y = beam.active ? beam.y : '0;

	// New mode is picked up on the first pixel of a frame only
	assign mode = beam.frame_start ? pattern_mode : mode_q;

	assign bar = 3'(beam.x / pos_t'(BAR_W));
	assign check = beam.x[5] ^ beam.y[5];

	always_comb begin
		case (mode)
			PAT_BARS: begin
				// White, yellow, cyan, green, magenta, red, blue, black
				pattern_rgb.red = {8{~bar[1]}};
				pattern_rgb.green = {8{~bar[2]}};
				pattern_rgb.blue = {8{~bar[0]}};
			end
			PAT_CHECKER: begin
				pattern_rgb = check ? '1 : '0; // 32 pixel squares
			end
			PAT_RAMP: begin
				pattern_rgb.red = beam.x[7:0];
				pattern_rgb.green = beam.y[7:0];
				pattern_rgb.blue = '0;
			end
			default: begin
				pattern_rgb = pixel_color;
			end
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			mode_q <= PAT_EXTERNAL;
			beam_d <= '{x: '0, y: '0, active: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1,
				frame_start: 1'b0};
		end else begin
			mode_q <= mode;
			beam_d <= beam; // Stays aligned with colour
		end
	end

	always_ff @(posedge clk_in) begin
		colour <= pattern_rgb;
	end

endmodule

/* src/vga_pkg.sv */
package vga_pkg;

	// Beam position, wide enough for 2047 pixels or lines
	typedef logic [10:0] pos_t;

	// One DAC channel
	typedef logic [7:0] colour_t;

	typedef enum logic [1:0] {
		PAT_EXTERNAL = 2'd0, // Colour from pixel_color
		PAT_BARS     = 2'd1,
		PAT_CHECKER  = 2'd2,
		PAT_RAMP     = 2'd3
	} pattern_mode_t;

	typedef enum logic [1:0] {
		SCAN_ACTIVE = 2'd0,
		SCAN_FRONT  = 2'd1,
		SCAN_PULSE  = 2'd2,
		SCAN_BACK   = 2'd3
	} scan_state_t;

	typedef struct packed {
		colour_t red;
		colour_t green;
		colour_t blue;
	} rgb_t;

	// Beam position plus the strobes and levels that go with it
	typedef struct packed {
		pos_t x;
		pos_t y;
		logic active;      // Both axes in active video
		logic hsync_n;
		logic vsync_n;
		logic frame_start; // First pixel of a frame
	} beam_t;

endpackage

/* src/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_PULSE = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 33
) (
	input logic clk_in,
	input logic reset,
	output vga_pkg::beam_t beam
);
	import vga_pkg::*;

	scan_state_t h_state;
	scan_state_t h_state_nx;
	scan_state_t v_state;
	scan_state_t v_state_nx;
	pos_t h_count;
	pos_t h_count_nx;
	pos_t v_count;
	pos_t v_count_nx;
	pos_t h_last; // Final count of the current horizontal state
	pos_t v_last;
	logic h_wrap;
	logic v_wrap;
	logic line_end;
	logic active_nx;
	beam_t beam_nx;

	// Last counter value of a state, counts are lengths
	function automatic pos_t last_index(
		scan_state_t s,
		int n_active,
		int n_front,
		int n_pulse,
		int n_back
	);
		int len;
		case (s)
			SCAN_ACTIVE: len = n_active;
			SCAN_FRONT: len = n_front;
			SCAN_PULSE: len = n_pulse;
			default: len = n_back;
		endcase
		return pos_t'(len - 1);
	endfunction

	function automatic scan_state_t step(scan_state_t s);
		scan_state_t nx;
		case (s)
			SCAN_ACTIVE: nx = SCAN_FRONT;
			SCAN_FRONT: nx = SCAN_PULSE;
			SCAN_PULSE: nx = SCAN_BACK;
			default: nx = SCAN_ACTIVE;
		endcase
		return nx;
	endfunction

	always_comb begin
		h_last = last_index(h_state, H_ACTIVE, H_FRONT, H_PULSE, H_BACK);
		v_last = last_index(v_state, V_ACTIVE, V_FRONT, V_PULSE, V_BACK);
		h_wrap = (h_count == h_last);
		v_wrap = (v_count == v_last);
		line_end = h_wrap && (h_state == SCAN_BACK); // Last back porch cycle

		h_state_nx = h_wrap ? step(h_state) : h_state;
		h_count_nx = h_wrap ? '0 : h_count + pos_t'(1);

		v_state_nx = v_state;
		v_count_nx = v_count;
		if (line_end) begin
			v_state_nx = v_wrap ? step(v_state) : v_state;
			v_count_nx = v_wrap ? '0 : v_count + pos_t'(1);
		end
	end

	// Beam fields from the next state, so the beam leaves a flop
	always_comb begin
		active_nx = (h_state_nx == SCAN_ACTIVE) && (v_state_nx == SCAN_ACTIVE);
		beam_nx.x = h_count_nx;
		beam_nx.y = v_count_nx;
		beam_nx.active = active_nx;
		beam_nx.hsync_n = (h_state_nx != SCAN_PULSE);
		beam_nx.vsync_n = (v_state_nx != SCAN_PULSE);
		beam_nx.frame_start = active_nx && (h_count_nx == '0) && (v_count_nx == '0);
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			h_state <= SCAN_ACTIVE;
			v_state <= SCAN_ACTIVE;
			h_count <= '0;
			v_count <= '0;
			beam <= '{x: '0, y: '0, active: 1'b1, hsync_n: 1'b1, vsync_n: 1'b1,
				frame_start: 1'b1}; // Matches the reset state
		end else begin
			h_state <= h_state_nx;
			v_state <= v_state_nx;
			h_count <= h_count_nx;
			v_count <= v_count_nx;
			beam <= beam_nx;
		end
	end

	// Counter always wraps before the length of its state
	assert property (@(posedge clk_in) disable iff (reset) h_count <= h_last)
		else $error("vga_timing: horizontal counter past end of state");

	// Vertical machine only moves on a line boundary
	assert property (@(posedge clk_in) disable iff (reset)
		(v_state != $past(v_state)) |-> $past(line_end))
		else $error("vga_timing: vertical state changed inside a line");

endmodule

/* src/vga_top.sv */
`timescale 1ns/1ps

module vga_top #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_PULSE = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 33
) (
	input logic clk_in, // 25 MHz pixel clock
	input logic reset,
	input vga_pkg::pattern_mode_t pattern_mode,
	input vga_pkg::rgb_t pixel_color,
	output vga_pkg::pos_t next_x,
	output vga_pkg::pos_t next_y,
	output logic hsync_n,
	output logic vsync_n,
	output logic blank_n,
	output vga_pkg::colour_t red,
	output vga_pkg::colour_t green,
	output vga_pkg::colour_t blue
);
	import vga_pkg::*;

	beam_t beam;
	beam_t beam_d; // One cycle behind beam
	rgb_t colour;

	vga_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_PULSE(H_PULSE),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_PULSE(V_PULSE),
		.V_BACK(V_BACK)
	) u_timing (
		.clk_in(clk_in),
		.reset(reset),
		.beam(beam)
	);

	vga_pixel_source #(
		.H_ACTIVE(H_ACTIVE)
	) u_pixel_source (
		.clk_in(clk_in),
		.reset(reset),
		.beam(beam),
		.pattern_mode(pattern_mode),
		.pixel_color(pixel_color),
		.next_x(next_x),
		.next_y(next_y),
		.colour(colour),
		.beam_d(beam_d)
	);

	vga_dac_output u_dac_output (
		.clk_in(clk_in),
		.reset(reset),
		.beam_d(beam_d),
		.colour(colour),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* vga_video.f */
+incdir+bench
src/vga_pkg.sv
src/vga_timing.sv
src/vga_pixel_source.sv
src/vga_dac_output.sv
src/vga_top.sv
bench/tb_vga_top.sv
